// ==== hdl/kbd_defs.svh ====
`ifndef KBD_DEFS_SVH
`define KBD_DEFS_SVH

// stable cycles before a button level is accepted
`define KBD_DEBOUNCE_CYCLES 16

// decoder buffer slots, also the receiver's starting credit
`define KBD_CREDITS 2

`define KBD_CODE_BREAK 8'hF0
`define KBD_CODE_EXT   8'hE0

// number row make codes
`define KBD_CODE_0 8'h45
`define KBD_CODE_1 8'h16
`define KBD_CODE_2 8'h1E
`define KBD_CODE_3 8'h26
`define KBD_CODE_4 8'h25
`define KBD_CODE_5 8'h2E
`define KBD_CODE_6 8'h36
`define KBD_CODE_7 8'h3D
`define KBD_CODE_8 8'h3E
`define KBD_CODE_9 8'h46

`endif

// ==== hdl/kbd_pkg.sv ====
package kbd_pkg;

	// one received PS/2 frame
	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
	} scan_byte_t;

	// digit event, error events have valid low and digit 15
	typedef struct packed {
		logic       valid;
		logic [3:0] digit;
	} key_event_t;

	// one pulse per button
	typedef struct packed {
		logic clear;
		logic blank_toggle;
		logic swap;
	} btn_cmd_t;

	typedef struct packed {
		logic [3:0] num1;
		logic [3:0] num2;
		logic [3:0] err_count;
		logic [3:0] zero;
		logic       blank;
	} disp_state_t;

	// active-low segments, gfedcba
	typedef struct packed {
		logic [6:0] tens;
		logic [6:0] ones;
	} seg_pair_t;

endpackage

// ==== hdl/debounce.sv ====
`timescale 1ns/1ns
`include "kbd_defs.svh"

module debounce (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_in,
	output logic o_neg
);

localparam int CNT_W = $clog2(`KBD_DEBOUNCE_CYCLES + 1);

logic [1:0] sync;
logic [CNT_W-1:0] stable_cnt;
logic level;
logic level_d;

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		sync <= 2'b11;
		stable_cnt <= '0;
		level <= 1'b1;
		level_d <= 1'b1;
		o_neg <= 1'b0;
	end else begin
		sync <= {sync[0], i_in};
		if (sync[1] == level) begin
			stable_cnt <= '0;
		end else if (stable_cnt == CNT_W'(`KBD_DEBOUNCE_CYCLES - 1)) begin
			// new level held long enough
			level <= sync[1];
			stable_cnt <= '0;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
		level_d <= level;
		// falling filtered level
		o_neg <= level_d & ~level;
	end
end

endmodule

// ==== hdl/ps2_frame_rx.sv ====
`timescale 1ns/1ns
`include "kbd_defs.svh"

module ps2_frame_rx (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_ps2_clk,
	input  logic i_ps2_data,
	input  logic i_credit,
	output logic o_byte_valid,
	output kbd_pkg::scan_byte_t o_byte
);

localparam int CW = $clog2(`KBD_CREDITS + 1);

logic [1:0] clk_sync;
logic [1:0] dat_sync;
logic clk_prev;
logic ps2_fall;
logic [10:0] shift;
logic [3:0] bit_cnt;
logic [9:0] idle_cnt;
logic frame_full;
logic frame_err;
logic [CW-1:0] credits;
logic send;

assign ps2_fall = clk_prev & ~clk_sync[1];

// start is bit 0, stop is bit 10, data plus parity must be odd
assign frame_err = shift[0] | ~shift[10] | ~(^shift[9:1]);
assign send = frame_full && (credits != '0);

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		clk_sync <= 2'b11;
		dat_sync <= 2'b11;
		clk_prev <= 1'b1;
	end else begin
		clk_sync <= {clk_sync[0], i_ps2_clk};
		dat_sync <= {dat_sync[0], i_ps2_data};
		clk_prev <= clk_sync[1];
	end
end

// frame bits arrive lsb first
always_ff @(posedge i_clk) begin
	if (ps2_fall) begin
		shift <= {dat_sync[1], shift[10:1]};
	end
end

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		bit_cnt <= '0;
		idle_cnt <= '0;
		frame_full <= 1'b0;
	end else begin
		frame_full <= 1'b0;
		if (!clk_sync[1]) begin
			idle_cnt <= '0;
		end else if (idle_cnt != '1) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
		if (ps2_fall) begin
			if (bit_cnt == 4'd10) begin
				bit_cnt <= '0;
				frame_full <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else if (idle_cnt == '1) begin
			// clock idle too long, drop partial frame
			bit_cnt <= '0;
		end
	end
end

// frames finishing without credit are lost
always_ff @(posedge i_clk) begin
	if (i_reset) begin
		o_byte_valid <= 1'b0;
		credits <= CW'(`KBD_CREDITS);
	end else begin
		o_byte_valid <= send;
		case ({send, i_credit})
			2'b10: credits <= credits - 1'b1;
			2'b01: credits <= credits + 1'b1;
			default: credits <= credits;
		endcase
	end
end

always_ff @(posedge i_clk) begin
	if (frame_full) begin
		o_byte.data <= shift[8:1];
		o_byte.parity_err <= frame_err;
	end
end

endmodule

// ==== hdl/scan_decoder.sv ====
`timescale 1ns/1ns
`include "kbd_defs.svh"

module scan_decoder (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_byte_valid,
	input  kbd_pkg::scan_byte_t i_byte,
	output logic o_credit,
	output kbd_pkg::key_event_t o_event
);

localparam int AW = (`KBD_CREDITS > 1) ? $clog2(`KBD_CREDITS) : 1;
localparam int CW = $clog2(`KBD_CREDITS + 1);

kbd_pkg::scan_byte_t fifo [`KBD_CREDITS];
kbd_pkg::scan_byte_t head;
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [CW-1:0] count;
logic pop;
logic brk_pend;
logic ext_pend;
logic is_digit;
logic [3:0] digit;

function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
	if (ptr == AW'(`KBD_CREDITS - 1)) begin
		next_ptr = '0;
	end else begin
		next_ptr = ptr + 1'b1;
	end
endfunction

// one byte leaves per cycle, each frees a slot
assign pop = (count != '0);
assign o_credit = pop;
assign head = fifo[rd_ptr];

always_ff @(posedge i_clk) begin
	if (i_byte_valid) begin
		fifo[wr_ptr] <= i_byte;
	end
end

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (i_byte_valid) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
		if (pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
		case ({i_byte_valid, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_comb begin
	is_digit = 1'b1;
	digit = 4'd0;
	case (head.data)
		`KBD_CODE_0: digit = 4'd0;
		`KBD_CODE_1: digit = 4'd1;
		`KBD_CODE_2: digit = 4'd2;
		`KBD_CODE_3: digit = 4'd3;
		`KBD_CODE_4: digit = 4'd4;
		`KBD_CODE_5: digit = 4'd5;
		`KBD_CODE_6: digit = 4'd6;
		`KBD_CODE_7: digit = 4'd7;
		`KBD_CODE_8: digit = 4'd8;
		`KBD_CODE_9: digit = 4'd9;
		default: is_digit = 1'b0;
	endcase
end

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		brk_pend <= 1'b0;
		ext_pend <= 1'b0;
		o_event <= '0;
	end else begin
		o_event <= '0;
		if (pop) begin
			if (head.parity_err) begin
				// error marker for the error counter
				o_event.digit <= 4'hF;
				brk_pend <= 1'b0;
				ext_pend <= 1'b0;
			end else if (head.data == `KBD_CODE_BREAK) begin
				brk_pend <= 1'b1;
			end else if (head.data == `KBD_CODE_EXT) begin
				ext_pend <= 1'b1;
			end else begin
				// plain make code only
				if (!brk_pend && !ext_pend && is_digit) begin
					o_event.valid <= 1'b1;
					o_event.digit <= digit;
				end
				brk_pend <= 1'b0;
				ext_pend <= 1'b0;
			end
		end
	end
end

endmodule

// ==== hdl/display_regs.sv ====
`timescale 1ns/1ns

module display_regs (
	input  logic i_clk,
	input  logic i_reset,
	input  kbd_pkg::key_event_t i_event,
	input  kbd_pkg::btn_cmd_t i_btn,
	output kbd_pkg::disp_state_t o_state
);

logic [3:0] num1;
logic [3:0] num2;
logic [3:0] err_count;
logic blank;
logic err_evt;

assign err_evt = !i_event.valid && (i_event.digit == 4'hF);

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		num1 <= 4'd0;
		num2 <= 4'd0;
		err_count <= 4'd0;
		blank <= 1'b0;
	end else if (i_btn != '0) begin
		// buttons take priority over keyboard events
		if (i_btn.clear) begin
			num1 <= 4'd0;
			num2 <= 4'd0;
		end else if (i_btn.swap) begin
			num1 <= num2;
			num2 <= num1;
		end
		if (i_btn.blank_toggle) begin
			blank <= ~blank;
		end
	end else if (i_event.valid) begin
		num2 <= num1;
		num1 <= i_event.digit;
	end else if (err_evt && err_count != 4'hF) begin
		// saturates at 15
		err_count <= err_count + 1'b1;
	end
end

assign o_state = '{
	num1: num1,
	num2: num2,
	err_count: err_count,
	zero: 4'd0,
	blank: blank
};

endmodule

// ==== hdl/seven_seg_driver.sv ====
`timescale 1ns/1ns

module seven_seg_driver (
	input  logic [3:0] i_hex,
	input  logic i_blank,
	output kbd_pkg::seg_pair_t o_seg
);

logic [3:0] tens;
logic [3:0] ones;

function automatic logic [6:0] digit_seg(input logic [3:0] d);
	case (d)
		4'd0: digit_seg = 7'b1000000;
		4'd1: digit_seg = 7'b1111001;
		4'd2: digit_seg = 7'b0100100;
		4'd3: digit_seg = 7'b0110000;
		4'd4: digit_seg = 7'b0011001;
		4'd5: digit_seg = 7'b0010010;
		4'd6: digit_seg = 7'b0000010;
		4'd7: digit_seg = 7'b1111000;
		4'd8: digit_seg = 7'b0000000;
		4'd9: digit_seg = 7'b0010000;
		default: digit_seg = 7'b1111111;
	endcase
endfunction

always_comb begin
	if (i_hex >= 4'd10) begin
		tens = 4'd1;
		ones = i_hex - 4'd10;
	end else begin
		tens = 4'd0;
		ones = i_hex;
	end
	// blanked display shows all segments off
	if (i_blank) begin
		o_seg = '1;
	end else begin
		o_seg.tens = digit_seg(tens);
		o_seg.ones = digit_seg(ones);
	end
end

endmodule

// ==== hdl/kbd_display_top.sv ====
`timescale 1ns/1ns

module kbd_display_top (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_ps2_clk,
	input  logic i_ps2_data,
	input  logic [2:0] i_key,
	output kbd_pkg::seg_pair_t o_hex [4]
);

logic [2:0] key_down;
kbd_pkg::btn_cmd_t btn;
logic byte_valid;
kbd_pkg::scan_byte_t scan_byte;
logic credit;
kbd_pkg::key_event_t key_event;
kbd_pkg::disp_state_t state;
logic [3:0] disp_val [4];

// buttons
for (genvar i = 0; i < 3; i++) begin : g_deb
	debounce deb (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_in(i_key[i]),
		.o_neg(key_down[i])
	);
end

assign btn = '{clear: key_down[0], blank_toggle: key_down[1], swap: key_down[2]};

// keyboard
ps2_frame_rx ps2_rx (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_ps2_clk(i_ps2_clk),
	.i_ps2_data(i_ps2_data),
	.i_credit(credit),
	.o_byte_valid(byte_valid),
	.o_byte(scan_byte)
);

scan_decoder scan_dec (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_byte_valid(byte_valid),
	.i_byte(scan_byte),
	.o_credit(credit),
	.o_event(key_event)
);

display_regs regs (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_event(key_event),
	.i_btn(btn),
	.o_state(state)
);

// hex pairs 0 to 3 show num1, num2, errors, zero
assign disp_val[0] = state.num1;
assign disp_val[1] = state.num2;
assign disp_val[2] = state.err_count;
assign disp_val[3] = state.zero;

for (genvar i = 0; i < 4; i++) begin : g_seg
	seven_seg_driver seven_dec (
		.i_hex(disp_val[i]),
		.i_blank(state.blank),
		.o_seg(o_hex[i])
	);
end

endmodule

// ==== bench/tb_ps2_host.sv ====
`timescale 1ns/1ns

module tb_ps2_host #(
	parameter int BIT_CYCLES = 40
) (
	input  logic i_clk,
	output logic o_ps2_clk,
	output logic o_ps2_data
);

// idle bus, both lines released high
initial begin
	o_ps2_clk = 1'b1;
	o_ps2_data = 1'b1;
end

task automatic clock_wait(input int n);
	repeat (n) @(posedge i_clk);
	#1;
endtask

// keyboard to host frame, data set while the clock is high
task automatic send_frame(input logic [7:0] data, input logic bad_parity);
	logic [10:0] frame;
	int i;
	// stop, odd parity, data, start
	frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
	for (i = 0; i < 11; i++) begin
		o_ps2_data = frame[i];
		clock_wait(BIT_CYCLES / 4);
		o_ps2_clk = 1'b0;
		clock_wait(BIT_CYCLES / 2);
		o_ps2_clk = 1'b1;
		clock_wait(BIT_CYCLES / 4);
	end
	o_ps2_data = 1'b1;
endtask

endmodule

// ==== bench/tb_kbd_display.sv ====
`timescale 1ns/1ns
`include "kbd_defs.svh"

module tb_kbd_display;

localparam int CLK_PERIOD = 8;
localparam int SETTLE = 64;
localparam int PS2_BIT_CYCLES = 40;
localparam int HOLD_CYCLES = `KBD_DEBOUNCE_CYCLES + 14;
localparam int N_DIRECTED = 40;
localparam int N_RANDOM = 200;
// longest item is an extended keystroke of five frames
localparam int ITEM_CYCLES = 5 * (11 * PS2_BIT_CYCLES + SETTLE);
localparam longint RUN_NS = longint'(N_DIRECTED + N_RANDOM) * ITEM_CYCLES * CLK_PERIOD;

logic clk;
logic reset;
logic [2:0] key;
logic ps2_clk;
logic ps2_data;
kbd_pkg::seg_pair_t hex [4];

// reference model
logic [3:0] m_num1;
logic [3:0] m_num2;
logic [3:0] m_err;
logic m_blank;
logic m_brk;
logic m_ext;

kbd_display_top uut (
	.i_clk(clk),
	.i_reset(reset),
	.i_ps2_clk(ps2_clk),
	.i_ps2_data(ps2_data),
	.i_key(key),
	.o_hex(hex)
);

tb_ps2_host #(.BIT_CYCLES(PS2_BIT_CYCLES)) ps2_host (
	.i_clk(clk),
	.o_ps2_clk(ps2_clk),
	.o_ps2_data(ps2_data)
);

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic fail_stop(input string msg);
	$display("%s", msg);
	$display("Simulation finished: FAIL");
	$fatal(1);
endtask

task automatic wait_cycles(input int n);
	repeat (n) @(posedge clk);
	#1;
endtask

function automatic logic [7:0] key_code(input int d);
	case (d)
		0: key_code = `KBD_CODE_0;
		1: key_code = `KBD_CODE_1;
		2: key_code = `KBD_CODE_2;
		3: key_code = `KBD_CODE_3;
		4: key_code = `KBD_CODE_4;
		5: key_code = `KBD_CODE_5;
		6: key_code = `KBD_CODE_6;
		7: key_code = `KBD_CODE_7;
		8: key_code = `KBD_CODE_8;
		default: key_code = `KBD_CODE_9;
	endcase
endfunction

// -1 when the code is not a number key
function automatic int code_digit(input logic [7:0] code);
	int d;
	code_digit = -1;
	for (d = 0; d < 10; d++) begin
		if (key_code(d) == code) begin
			code_digit = d;
		end
	end
endfunction

function automatic logic [7:0] random_other_code();
	logic [7:0] code;
	do begin
		code = 8'($urandom_range(0, 255));
	end while (code_digit(code) >= 0 || code == `KBD_CODE_BREAK || code == `KBD_CODE_EXT);
	return code;
endfunction

// active low gfedcba patterns
function automatic logic [6:0] seg_digit(input int d);
	case (d)
		0: seg_digit = 7'h40;
		1: seg_digit = 7'h79;
		2: seg_digit = 7'h24;
		3: seg_digit = 7'h30;
		4: seg_digit = 7'h19;
		5: seg_digit = 7'h12;
		6: seg_digit = 7'h02;
		7: seg_digit = 7'h78;
		8: seg_digit = 7'h00;
		default: seg_digit = 7'h10;
	endcase
endfunction

function automatic kbd_pkg::seg_pair_t seg_expect(input logic [3:0] v, input logic blank);
	kbd_pkg::seg_pair_t s;
	if (blank) begin
		s = '1;
	end else begin
		s.tens = seg_digit(int'(v) / 10);
		s.ones = seg_digit(int'(v) % 10);
	end
	return s;
endfunction

task automatic compare_seg_pair(input string name, input kbd_pkg::seg_pair_t got,
		input kbd_pkg::seg_pair_t exp);
	if (got !== exp) begin
		fail_stop($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	end
endtask

task automatic check_displays();
	logic [3:0] vals [4];
	int i;
	vals[0] = m_num1;
	vals[1] = m_num2;
	vals[2] = m_err;
	vals[3] = 4'd0;
	for (i = 0; i < 4; i++) begin
		compare_seg_pair($sformatf("o_hex[%0d]", i), hex[i], seg_expect(vals[i], m_blank));
	end
endtask

task automatic model_byte(input logic [7:0] code, input logic bad);
	int d;
	d = code_digit(code);
	if (bad) begin
		if (m_err != 4'hF) begin
			m_err = m_err + 4'd1;
		end
	end else if (code == `KBD_CODE_BREAK) begin
		m_brk = 1'b1;
	end else if (code == `KBD_CODE_EXT) begin
		m_ext = 1'b1;
	end else begin
		if (!m_brk && !m_ext && d >= 0) begin
			m_num2 = m_num1;
			m_num1 = 4'(d);
		end
		m_brk = 1'b0;
		m_ext = 1'b0;
	end
endtask

task automatic send_byte(input logic [7:0] code, input logic bad);
	ps2_host.send_frame(code, bad);
	model_byte(code, bad);
	wait_cycles(SETTLE);
	check_displays();
endtask

// make then break with an optional E0 prefix
task automatic type_key(input logic [7:0] code, input logic ext);
	if (ext) begin
		send_byte(`KBD_CODE_EXT, 1'b0);
	end
	send_byte(code, 1'b0);
	if (ext) begin
		send_byte(`KBD_CODE_EXT, 1'b0);
	end
	send_byte(`KBD_CODE_BREAK, 1'b0);
	send_byte(code, 1'b0);
endtask

task automatic press_button(input int b);
	logic [3:0] old_num1;
	key[b] = 1'b0;
	wait_cycles(HOLD_CYCLES);
	key[b] = 1'b1;
	case (b)
		0: begin
			m_num1 = 4'd0;
			m_num2 = 4'd0;
		end
		1: m_blank = ~m_blank;
		default: begin
			old_num1 = m_num1;
			m_num1 = m_num2;
			m_num2 = old_num1;
		end
	endcase
	wait_cycles(SETTLE);
	check_displays();
endtask

task automatic glitch_button(input int b);
	int len;
	len = $urandom_range(1, `KBD_DEBOUNCE_CYCLES - 4);
	key[b] = 1'b0;
	wait_cycles(len);
	key[b] = 1'b1;
	wait_cycles(SETTLE);
	check_displays();
endtask

task automatic random_item();
	int kind;
	kind = $urandom_range(0, 9);
	case (kind)
		0, 1, 2, 3: type_key(key_code($urandom_range(0, 9)), 1'b0);
		4: type_key(random_other_code(), 1'b0);
		5: type_key(key_code($urandom_range(0, 9)), 1'b1);
		6: send_byte(8'($urandom_range(0, 255)), 1'b1);
		7, 8: press_button($urandom_range(0, 2));
		default: glitch_button($urandom_range(0, 2));
	endcase
endtask

initial begin
	#(RUN_NS * 3 / 2);
	fail_stop("Timeout: the run did not finish in the expected time");
end

initial begin
	int i;
	clk = 1'b0;
	reset = 1'b1;
	key = 3'b111;
	m_num1 = 4'd0;
	m_num2 = 4'd0;
	m_err = 4'd0;
	m_blank = 1'b0;
	m_brk = 1'b0;
	m_ext = 1'b0;
	void'($urandom(32'h9fb4_8d6f));
	repeat (3) @(posedge clk);
	#1;
	reset = 1'b0;
	wait_cycles(4);
	check_displays();

	for (i = 0; i < 6; i++) begin
		type_key(key_code($urandom_range(0, 9)), 1'b0);
	end
	for (i = 0; i < 3; i++) begin
		type_key(random_other_code(), 1'b0);
	end
	for (i = 0; i < 3; i++) begin
		type_key(key_code($urandom_range(0, 9)), 1'b1);
	end
	// enough to reach saturation
	for (i = 0; i < 17; i++) begin
		send_byte(8'($urandom_range(0, 255)), 1'b1);
	end
	press_button(2);
	press_button(1);
	press_button(1);
	press_button(0);
	for (i = 0; i < 3; i++) begin
		glitch_button(i);
	end

	for (i = 0; i < N_RANDOM; i++) begin
		random_item();
	end

	$display("Simulation finished: PASS");
	$finish;
end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/kbd_pkg.sv
hdl/debounce.sv
hdl/ps2_frame_rx.sv
hdl/scan_decoder.sv
hdl/display_regs.sv
hdl/seven_seg_driver.sv
hdl/kbd_display_top.sv
bench/tb_ps2_host.sv
bench/tb_kbd_display.sv

// ==== Bender.yml ====
package:
  name: kbd_display

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/kbd_pkg.sv
      - hdl/debounce.sv
      - hdl/ps2_frame_rx.sv
      - hdl/scan_decoder.sv
      - hdl/display_regs.sv
      - hdl/seven_seg_driver.sv
      - hdl/kbd_display_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/tb_ps2_host.sv
      - bench/tb_kbd_display.sv
